// ==== src/l2_mem_pkg.sv ====
// geometry, field types and sweep states shared by the L2 local memory
// import with a wildcard in each module header

package l2_mem_pkg;

    // way geometry
    localparam int L2_WAYS = 4;
    localparam int L2_WAY_BITS = 2;

    // set geometry
    localparam int L2_SET_BITS = 6;
    localparam int L2_SETS = 64;

    // banks are picked by the top set bits
    localparam int L2_BANK_BITS = 1;
    localparam int L2_BANKS = 2;
    localparam int L2_BANK_SET_BITS = L2_SET_BITS - L2_BANK_BITS;
    localparam int L2_BANK_SETS = L2_SETS / L2_BANKS;

    // field widths
    localparam int L2_TAG_BITS = 12;
    localparam int L2_STATE_BITS = 3;
    localparam int LINE_BITS = 128;

    // coherence state written into every way by the reset sweep
    localparam logic [L2_STATE_BITS-1:0] STATE_INVALID = '0;

    // set index
    typedef logic [L2_SET_BITS-1:0] l2_set_t;

    // way number, also the evict pointer
    typedef logic [L2_WAY_BITS-1:0] l2_way_t;

    // tag
    typedef logic [L2_TAG_BITS-1:0] l2_tag_t;

    // coherence state
    typedef logic [L2_STATE_BITS-1:0] state_t;

    // protection attribute
    typedef logic [0:0] hprot_t;

    // cache line
    typedef logic [LINE_BITS-1:0] line_t;

    // reset sweep FSM
    typedef enum logic {
        INIT_SWEEP,
        INIT_DONE
    } init_state_t;

endpackage

// ==== src/dp_ram.sv ====
// behavioral true dual-port RAM, read-first, registered outputs
// outputs only update while ce is high, writes go through regardless

`timescale 1ns/1ps

module dp_ram #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr_a,
    input  logic [$clog2(DEPTH)-1:0] addr_b,
    input  logic [WIDTH-1:0]         din_a,
    input  logic [WIDTH-1:0]         din_b,
    input  logic                     we_a,
    input  logic                     we_b,
    input  logic                     ce,
    output logic [WIDTH-1:0]         dout_a,
    output logic [WIDTH-1:0]         dout_b
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        // old contents come out when reading and writing the same word
        if (ce) begin
            dout_a <= mem[addr_a];
            dout_b <= mem[addr_b];
        end
        if (we_a) begin
            mem[addr_a] <= din_a;
        end
        if (we_b) begin
            mem[addr_b] <= din_b;
        end
    end

endmodule

// ==== src/l2_init_sweep.sv ====
// after reset, steps through every set so all ways get the invalid state
// ready goes high once the last set has been written

`timescale 1ns/1ps

module l2_init_sweep import l2_mem_pkg::*; (
    input  logic    clk,
    input  logic    wr_rst,
    output logic    init_busy,
    output l2_set_t init_set,
    output logic    ready
);

    init_state_t state;
    l2_set_t     set_cnt;

    always_ff @(posedge clk) begin
        if (wr_rst) begin
            state <= INIT_SWEEP;
            set_cnt <= '0;
        end else begin
            case (state)
                INIT_SWEEP: begin
                    // one set per cycle
                    set_cnt <= set_cnt + 1'b1;
                    if (set_cnt == l2_set_t'(L2_SETS - 1)) begin
                        state <= INIT_DONE;
                    end
                end
                default: begin
                    set_cnt <= '0;
                end
            endcase
        end
    end

    assign init_busy = (state == INIT_SWEEP);
    assign init_set = set_cnt;
    assign ready = (state == INIT_DONE);

endmodule

// ==== src/l2_wr_ctrl.sv ====
// turns the way number and field strobes into per-way write enables
// while the reset sweep runs, only the state field is written, in all ways

`timescale 1ns/1ps

module l2_wr_ctrl import l2_mem_pkg::*; (
    input  l2_set_t            set_in,
    input  l2_way_t            way,
    input  state_t             wr_data_state,
    input  logic               wr_en_line,
    input  logic               wr_en_state,
    input  logic               wr_en_evict_way,
    input  logic               wr_en_put_reqs,
    input  logic               init_busy,
    input  l2_set_t            init_set,
    output l2_set_t            wr_set,
    output state_t             wr_state,
    output logic [L2_WAYS-1:0] we_tag,
    output logic [L2_WAYS-1:0] we_state,
    output logic [L2_WAYS-1:0] we_hprot,
    output logic [L2_WAYS-1:0] we_line,
    output logic               we_evict
);

    logic [L2_WAYS-1:0] way_oh;

    // one-hot way select
    always_comb begin
        way_oh = '0;
        for (int i = 0; i < L2_WAYS; i++) begin
            if (way == l2_way_t'(i)) begin
                way_oh[i] = 1'b1;
            end
        end
    end

    always_comb begin
        if (init_busy) begin
            // sweep owns the write port
            wr_set = init_set;
            wr_state = STATE_INVALID;
            we_tag = '0;
            we_state = '1;
            we_hprot = '0;
            we_line = '0;
            we_evict = 1'b0;
        end else begin
            wr_set = set_in;
            wr_state = wr_data_state;
            we_tag = '0;
            we_state = '0;
            we_hprot = '0;
            we_line = '0;
            we_evict = wr_en_evict_way;

            // a put request fills every field of the way
            if (wr_en_put_reqs) begin
                we_tag = way_oh;
                we_hprot = way_oh;
            end
            if (wr_en_state || wr_en_put_reqs) begin
                we_state = way_oh;
            end
            if (wr_en_line || wr_en_put_reqs) begin
                we_line = way_oh;
            end
        end
    end

endmodule

// ==== src/l2_field_array.sv ====
// storage for one per-way field across all ways and banks
// each RAM holds a way pair, even way on port A and odd way on port B

`timescale 1ns/1ps

module l2_field_array import l2_mem_pkg::*; #(
    parameter int WIDTH = 8
) (
    input  logic               clk,
    input  logic               rd_en,
    input  l2_set_t            rd_set,
    input  l2_set_t            wr_set,
    input  logic [WIDTH-1:0]   wr_data,
    input  logic [L2_WAYS-1:0] we,
    output logic [WIDTH-1:0]   rd_data [L2_WAYS]
);

    logic [L2_BANK_BITS-1:0]     wr_bank;
    logic [L2_BANK_BITS-1:0]     rd_bank;
    logic [L2_BANK_BITS-1:0]     rd_bank_q;
    logic [L2_BANK_SET_BITS-1:0] wr_lo;
    logic [L2_BANK_SET_BITS-1:0] rd_lo;
    logic [WIDTH-1:0]            bank_dout [L2_BANKS][L2_WAYS];

    assign wr_bank = wr_set[L2_SET_BITS-1 -: L2_BANK_BITS];
    assign rd_bank = rd_set[L2_SET_BITS-1 -: L2_BANK_BITS];
    assign wr_lo = wr_set[L2_BANK_SET_BITS-1:0];
    assign rd_lo = rd_set[L2_BANK_SET_BITS-1:0];

    for (genvar b = 0; b < L2_BANKS; b++) begin : g_bank
        for (genvar p = 0; p < L2_WAYS / 2; p++) begin : g_pair
            logic                        we_a;
            logic                        we_b;
            logic [L2_BANK_SET_BITS-1:0] set_a;
            logic [L2_BANK_SET_BITS-1:0] set_b;

            assign we_a = we[2*p] && (wr_bank == L2_BANK_BITS'(b));
            assign we_b = we[2*p+1] && (wr_bank == L2_BANK_BITS'(b));
            // a writing port takes the write set, otherwise the read set
            assign set_a = we_a ? wr_lo : rd_lo;
            assign set_b = we_b ? wr_lo : rd_lo;

            dp_ram #(
                .WIDTH(WIDTH),
                .DEPTH(2 * L2_BANK_SETS)
            ) ram (
                .clk(clk),
                .addr_a({1'b0, set_a}),
                .addr_b({1'b1, set_b}),
                .din_a(wr_data),
                .din_b(wr_data),
                .we_a(we_a),
                .we_b(we_b),
                .ce(rd_en),
                .dout_a(bank_dout[b][2*p]),
                .dout_b(bank_dout[b][2*p+1])
            );
        end
    end

    // bank select follows the RAM output register
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_bank_q <= rd_bank;
        end
    end

    always_comb begin
        for (int w = 0; w < L2_WAYS; w++) begin
            rd_data[w] = bank_dout[rd_bank_q][w];
        end
    end

endmodule

// ==== src/l2_evict_array.sv ====
// per-set evict-way pointer, banked like the field arrays
// only port A of each bank RAM is used

`timescale 1ns/1ps

module l2_evict_array import l2_mem_pkg::*; (
    input  logic    clk,
    input  logic    rd_en,
    input  l2_set_t rd_set,
    input  l2_set_t wr_set,
    input  l2_way_t wr_data,
    input  logic    we,
    output l2_way_t rd_data
);

    logic [L2_BANK_BITS-1:0]     wr_bank;
    logic [L2_BANK_BITS-1:0]     rd_bank;
    logic [L2_BANK_BITS-1:0]     rd_bank_q;
    logic [L2_BANK_SET_BITS-1:0] wr_lo;
    logic [L2_BANK_SET_BITS-1:0] rd_lo;
    l2_way_t                     bank_dout [L2_BANKS];

    assign wr_bank = wr_set[L2_SET_BITS-1 -: L2_BANK_BITS];
    assign rd_bank = rd_set[L2_SET_BITS-1 -: L2_BANK_BITS];
    assign wr_lo = wr_set[L2_BANK_SET_BITS-1:0];
    assign rd_lo = rd_set[L2_BANK_SET_BITS-1:0];

    for (genvar b = 0; b < L2_BANKS; b++) begin : g_bank
        logic we_bank;

        assign we_bank = we && (wr_bank == L2_BANK_BITS'(b));

        dp_ram #(
            .WIDTH(L2_WAY_BITS),
            .DEPTH(L2_BANK_SETS)
        ) ram (
            .clk(clk),
            .addr_a(we_bank ? wr_lo : rd_lo),
            .addr_b('0),
            .din_a(wr_data),
            .din_b('0),
            .we_a(we_bank),
            .we_b(1'b0),
            .ce(rd_en),
            .dout_a(bank_dout[b]),
            .dout_b()
        );
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_bank_q <= rd_bank;
        end
    end

    assign rd_data = bank_dout[rd_bank_q];

endmodule

// ==== src/l2_localmem.sv ====
// L2 cache local memory: tag, state, hprot and line arrays per way plus evict pointers
// wait for ready after wr_rst, then write with the field strobes and read all ways with rd_en

`timescale 1ns/1ps

module l2_localmem import l2_mem_pkg::*; (
    input  logic    clk,
    input  logic    wr_rst,
    input  l2_set_t set_in,
    input  l2_way_t way,
    input  logic    rd_en,
    input  line_t   wr_data_line,
    input  l2_tag_t wr_data_tag,
    input  hprot_t  wr_data_hprot,
    input  l2_way_t wr_data_evict_way,
    input  state_t  wr_data_state,
    input  logic    wr_en_line,
    input  logic    wr_en_state,
    input  logic    wr_en_evict_way,
    input  logic    wr_en_put_reqs,
    output logic    ready,
    output line_t   rd_data_line [L2_WAYS],
    output l2_tag_t rd_data_tag [L2_WAYS],
    output hprot_t  rd_data_hprot [L2_WAYS],
    output state_t  rd_data_state [L2_WAYS],
    output l2_way_t rd_data_evict_way
);

    logic               init_busy;
    l2_set_t            init_set;
    l2_set_t            wr_set;
    state_t             wr_state;
    logic [L2_WAYS-1:0] we_tag;
    logic [L2_WAYS-1:0] we_state;
    logic [L2_WAYS-1:0] we_hprot;
    logic [L2_WAYS-1:0] we_line;
    logic               we_evict;

    l2_init_sweep sweep (
        .clk(clk),
        .wr_rst(wr_rst),
        .init_busy(init_busy),
        .init_set(init_set),
        .ready(ready)
    );

    l2_wr_ctrl wr_ctrl (
        .set_in(set_in),
        .way(way),
        .wr_data_state(wr_data_state),
        .wr_en_line(wr_en_line),
        .wr_en_state(wr_en_state),
        .wr_en_evict_way(wr_en_evict_way),
        .wr_en_put_reqs(wr_en_put_reqs),
        .init_busy(init_busy),
        .init_set(init_set),
        .wr_set(wr_set),
        .wr_state(wr_state),
        .we_tag(we_tag),
        .we_state(we_state),
        .we_hprot(we_hprot),
        .we_line(we_line),
        .we_evict(we_evict)
    );

    l2_field_array #(.WIDTH(L2_TAG_BITS)) tag_array (
        .clk(clk),
        .rd_en(rd_en),
        .rd_set(set_in),
        .wr_set(wr_set),
        .wr_data(wr_data_tag),
        .we(we_tag),
        .rd_data(rd_data_tag)
    );

    // state data is muxed with the sweep value in wr_ctrl
    l2_field_array #(.WIDTH(L2_STATE_BITS)) state_array (
        .clk(clk),
        .rd_en(rd_en),
        .rd_set(set_in),
        .wr_set(wr_set),
        .wr_data(wr_state),
        .we(we_state),
        .rd_data(rd_data_state)
    );

    l2_field_array #(.WIDTH(1)) hprot_array (
        .clk(clk),
        .rd_en(rd_en),
        .rd_set(set_in),
        .wr_set(wr_set),
        .wr_data(wr_data_hprot),
        .we(we_hprot),
        .rd_data(rd_data_hprot)
    );

    l2_field_array #(.WIDTH(LINE_BITS)) line_array (
        .clk(clk),
        .rd_en(rd_en),
        .rd_set(set_in),
        .wr_set(wr_set),
        .wr_data(wr_data_line),
        .we(we_line),
        .rd_data(rd_data_line)
    );

    l2_evict_array evict_array (
        .clk(clk),
        .rd_en(rd_en),
        .rd_set(set_in),
        .wr_set(wr_set),
        .wr_data(wr_data_evict_way),
        .we(we_evict),
        .rd_data(rd_data_evict_way)
    );

endmodule

// ==== verification/l2_localmem_asserts.sv ====
// checks on the write enables and ready of the L2 local memory
// bound into l2_localmem by the bind at the end, compiled with the testbench

`timescale 1ns/1ps

module l2_localmem_asserts import l2_mem_pkg::*; (
    input logic               clk,
    input logic               wr_rst,
    input logic               ready,
    input logic               init_busy,
    input logic [L2_WAYS-1:0] we_tag,
    input logic [L2_WAYS-1:0] we_line,
    input logic               we_evict
);

    // a put request targets one way only
    tag_one_way: assert property (@(posedge clk) disable iff (wr_rst)
        !init_busy |-> $onehot0(we_tag))
        else $error("tag write enable active for more than one way");

    // the sweep writes state only
    sweep_state_only: assert property (@(posedge clk) disable iff (wr_rst)
        init_busy |-> (we_tag == '0 && we_line == '0 && !we_evict))
        else $error("tag, line or evict write enable active during the sweep");

    ready_holds: assert property (@(posedge clk)
        ready && !wr_rst |=> ready)
        else $error("ready fell without a reset");

endmodule

bind l2_localmem l2_localmem_asserts asserts0 (
    .clk(clk),
    .wr_rst(wr_rst),
    .ready(ready),
    .init_busy(init_busy),
    .we_tag(we_tag),
    .we_line(we_line),
    .we_evict(we_evict)
);

// ==== verification/tb_l2_localmem.sv ====
// directed testbench for the L2 local memory, keeps a per-set, per-way reference model
// top module tb_l2_localmem, built from the project file list

`timescale 1ns/1ps

module tb_l2_localmem import l2_mem_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int N_PUT = 12;
    localparam int N_EVICT = 8;
    // two cycles per access, sweep reads plus the later tests
    localparam int TEST_CYCLES = 2 * (L2_SETS + 6 * N_PUT + 3 * N_EVICT + 24);
    // reset, sweep and the tests, doubled as margin
    localparam int TIMEOUT_CYCLES = 2 + L2_SETS + 2 * TEST_CYCLES;
    // op bits line up with the strobe concatenation in access
    localparam logic [4:0] OP_RD = 5'b00001;
    localparam logic [4:0] OP_PUT = 5'b00010;
    localparam logic [4:0] OP_STATE = 5'b00100;
    localparam logic [4:0] OP_LINE = 5'b01000;
    localparam logic [4:0] OP_EVICT = 5'b10000;

    logic    clk, wr_rst, rd_en, ready;
    logic    wr_en_line, wr_en_state, wr_en_evict_way, wr_en_put_reqs;
    l2_set_t set_in;
    l2_way_t way, wr_data_evict_way, rd_data_evict_way;
    line_t   wr_data_line;
    l2_tag_t wr_data_tag;
    hprot_t  wr_data_hprot;
    state_t  wr_data_state;
    line_t   rd_data_line [L2_WAYS];
    l2_tag_t rd_data_tag [L2_WAYS];
    hprot_t  rd_data_hprot [L2_WAYS];
    state_t  rd_data_state [L2_WAYS];

    // reference model
    l2_tag_t m_tag [L2_SETS][L2_WAYS];
    state_t  m_state [L2_SETS][L2_WAYS];
    hprot_t  m_hprot [L2_SETS][L2_WAYS];
    line_t   m_line [L2_SETS][L2_WAYS];
    l2_way_t m_evict [L2_SETS];
    int      errors = 0;
    int      checks = 0;

    l2_localmem dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input line_t expected, input line_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_set(input string name, input l2_set_t s);
        for (int w = 0; w < L2_WAYS; w++) begin
            check($sformatf("%s set %0d tag way %0d", name, s, w),
                  line_t'(m_tag[s][w]), line_t'(rd_data_tag[w]));
            check($sformatf("%s set %0d state way %0d", name, s, w),
                  line_t'(m_state[s][w]), line_t'(rd_data_state[w]));
            check($sformatf("%s set %0d hprot way %0d", name, s, w),
                  line_t'(m_hprot[s][w]), line_t'(rd_data_hprot[w]));
            check($sformatf("%s set %0d line way %0d", name, s, w), m_line[s][w], rd_data_line[w]);
        end
        check($sformatf("%s set %0d evict", name, s), line_t'(m_evict[s]),
              line_t'(rd_data_evict_way));
    endtask

    // one strobe cycle with fresh random data; a read compares against the model before the write
    task automatic access(input string name, input l2_set_t s, input l2_way_t w,
                          input logic [4:0] op);
        l2_tag_t tag;
        state_t  st;
        hprot_t  hp;
        line_t   ln;
        l2_way_t ev;
        tag = l2_tag_t'($urandom);
        st = state_t'($urandom);
        hp = hprot_t'($urandom);
        ln = {$urandom, $urandom, $urandom, $urandom};
        ev = l2_way_t'($urandom);
        @(posedge clk);
        set_in <= s;
        way <= w;
        wr_data_tag <= tag;
        wr_data_state <= st;
        wr_data_hprot <= hp;
        wr_data_line <= ln;
        wr_data_evict_way <= ev;
        {wr_en_evict_way, wr_en_line, wr_en_state, wr_en_put_reqs, rd_en} <= op;
        @(posedge clk);
        {wr_en_evict_way, wr_en_line, wr_en_state, wr_en_put_reqs, rd_en} <= '0;
        @(negedge clk);
        if (|(op & OP_RD)) compare_set(name, s);
        if (|(op & OP_PUT)) begin
            m_tag[s][w] = tag;
            m_hprot[s][w] = hp;
        end
        if (|(op & (OP_PUT | OP_STATE))) m_state[s][w] = st;
        if (|(op & (OP_PUT | OP_LINE))) m_line[s][w] = ln;
        if (|(op & OP_EVICT)) m_evict[s] = ev;
    endtask

    task automatic fill_set(input l2_set_t s);
        for (int w = 0; w < L2_WAYS; w++) begin
            access("fill", s, l2_way_t'(w), OP_PUT);
        end
    endtask

    task automatic test_sweep();
        int cycles;
        cycles = 0;
        for (int s = 0; s < L2_SETS; s++) begin
            for (int w = 0; w < L2_WAYS; w++) begin
                m_state[s][w] = STATE_INVALID;
            end
        end
        repeat (2) @(posedge clk);
        wr_rst <= 1'b0;
        while (!ready && cycles < 4 * L2_SETS) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
        end
        check("sweep ready delay", line_t'(L2_SETS), line_t'(cycles));
        for (int s = 0; s < L2_SETS; s++) begin
            access("sweep", l2_set_t'(s), '0, OP_RD);
        end
    endtask

    task automatic test_put();
        l2_set_t s;
        wait (ready);
        repeat (N_PUT) begin
            s = l2_set_t'($urandom);
            fill_set(s);
            access("put", s, l2_way_t'($urandom), OP_PUT);
            access("put", s, l2_way_t'($urandom), OP_RD);
        end
    endtask

    task automatic test_fields();
        l2_set_t s;
        l2_way_t w;
        wait (ready);
        s = l2_set_t'($urandom);
        w = l2_way_t'($urandom);
        fill_set(s);
        access("state only", s, w, OP_STATE);
        access("state only", s, w, OP_RD);
        access("line only", s, w, OP_LINE);
        access("line only", s, w, OP_RD);
    endtask

    // same low set bits, only the bank bit differs
    task automatic test_banks();
        l2_set_t s_lo;
        l2_set_t s_hi;
        l2_way_t w;
        wait (ready);
        s_lo = l2_set_t'($urandom) & l2_set_t'(L2_BANK_SETS - 1);
        s_hi = s_lo | l2_set_t'(L2_BANK_SETS);
        w = l2_way_t'($urandom);
        access("bank low", s_lo, w, OP_PUT);
        access("bank high", s_hi, w, OP_PUT);
        access("bank low", s_lo, w, OP_RD);
        access("bank high", s_hi, w, OP_RD);
    endtask

    task automatic test_evict();
        l2_set_t s;
        l2_way_t w;
        wait (ready);
        repeat (N_EVICT) begin
            s = l2_set_t'($urandom);
            w = l2_way_t'($urandom);
            access("evict", s, w, OP_EVICT);
            access("evict", s, w, OP_RD);
            access("evict other way", s, ~w, OP_RD);
        end
    endtask

    task automatic test_read_first();
        l2_set_t s;
        l2_way_t w;
        wait (ready);
        s = l2_set_t'($urandom);
        w = l2_way_t'($urandom);
        fill_set(s);
        fill_set(l2_set_t'(s ^ 1));
        access("read first", s, w, OP_RD);
        // neighbour set is written and addressed with rd_en low
        access("hold", l2_set_t'(s ^ 1), w, OP_PUT);
        compare_set("hold", s);
        access("same cycle", s, w, OP_PUT | OP_RD);
        access("after write", s, w, OP_RD);
    endtask

    initial begin
        void'($urandom(32'hfea9_1c8b));
        clk = 1'b0;
        wr_rst = 1'b1;
        {wr_en_evict_way, wr_en_line, wr_en_state, wr_en_put_reqs, rd_en} = '0;
        {set_in, way, wr_data_line, wr_data_tag, wr_data_hprot} = '0;
        {wr_data_evict_way, wr_data_state} = '0;
        test_sweep();
        test_put();
        test_fields();
        test_banks();
        test_evict();
        test_read_first();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== l2_localmem.f ====
src/l2_mem_pkg.sv
src/dp_ram.sv
src/l2_init_sweep.sv
src/l2_wr_ctrl.sv
src/l2_field_array.sv
src/l2_evict_array.sv
src/l2_localmem.sv
verification/l2_localmem_asserts.sv
verification/tb_l2_localmem.sv

// ==== Makefile ====
# Verilator build and run of the L2 local memory testbench
TOP := tb_l2_localmem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f l2_localmem.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f l2_localmem.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@grep -qx "Simulation passed" sim.log || (echo "no pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
